// File: include/spi_word_macros.svh
// width and depth constants for the SPI word target port
// include wherever word, counter or synchronizer sizes are needed
`ifndef SPI_WORD_MACROS_SVH
`define SPI_WORD_MACROS_SVH

// bits per SPI word, shifted MSB first
`define SPI_WORD_W 64

// bit counter width, holds 0..63 with headroom
`define SPI_CNT_W 7

// flops per pin in the input synchronizer
`define SPI_SYNC_STAGES 2

`endif

// File: verilog/spi_word_pkg.sv
// shared types for the SPI word target port
// referenced by scoped name from the synchronizer, shifter and top level
`include "spi_word_macros.svh"

package spi_word_pkg;

  // one SPI word, either direction
  typedef logic [`SPI_WORD_W-1:0] word_t;

  // bits seen so far in the current word
  typedef logic [`SPI_CNT_W-1:0] bit_cnt_t;

  // synchronized pin levels plus one-clk event pulses
  typedef struct packed {
    logic sck_rise;   // sck went 0 -> 1
    logic sck_fall;   // sck went 1 -> 0
    logic cs_active;  // cs pin low
    logic cs_start;   // cs just fell
    logic copi;       // data bit from controller
  } spi_pins_t;

  // shifter FSM
  typedef enum logic {
    st_idle,
    st_shift
  } shift_state_t;

endpackage

// File: verilog/spi_pin_sync.sv
// brings the async SCK, CS and COPI pins into the clk domain
// and turns them into edge pulses for the word shifter
`timescale 1ns/10ps
`include "spi_word_macros.svh"

module spi_pin_sync (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   sck,
  input  logic                   cs,    // active low
  input  logic                   copi,
  output spi_word_pkg::spi_pins_t pins
);

  // ########################################
  // synchronizer chains
  // ########################################
  logic [`SPI_SYNC_STAGES-1:0] sck_sync;
  logic [`SPI_SYNC_STAGES-1:0] cs_sync;
  logic [`SPI_SYNC_STAGES-1:0] copi_sync;

  logic sck_s;   // last stage outputs
  logic cs_s;
  logic copi_s;
  logic sck_prev; // one clk older than sck_s
  logic cs_prev;

  assign sck_s  = sck_sync[`SPI_SYNC_STAGES-1];
  assign cs_s   = cs_sync[`SPI_SYNC_STAGES-1];
  assign copi_s = copi_sync[`SPI_SYNC_STAGES-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_sync  <= '0;   // sck idles low in mode 0
      cs_sync   <= '1;   // deselected
      copi_sync <= '0;
      sck_prev  <= 1'b0;
      cs_prev   <= 1'b1;
    end else begin
      sck_sync  <= {sck_sync[`SPI_SYNC_STAGES-2:0], sck};
      cs_sync   <= {cs_sync[`SPI_SYNC_STAGES-2:0], cs};
      copi_sync <= {copi_sync[`SPI_SYNC_STAGES-2:0], copi};
      sck_prev  <= sck_s;
      cs_prev   <= cs_s;
    end
  end

  // ########################################
  // edge register, all fields aligned
  // ########################################
  always_ff @(posedge clk) begin
    if (rst) begin
      pins <= '0;
    end else begin
      pins.sck_rise  <= sck_s & ~sck_prev;
      pins.sck_fall  <= ~sck_s & sck_prev;
      pins.cs_active <= ~cs_s;
      pins.cs_start  <= ~cs_s & cs_prev;   // falling cs
      pins.copi      <= copi_s;
    end
  end

endmodule

// File: verilog/spi_word_shifter.sv
// SPI mode 0 word engine that receives and sends 64-bit words MSB first
// runs off the event bundle from spi_pin_sync and gives one word strobe per 64 bits
`timescale 1ns/10ps
`include "spi_word_macros.svh"

module spi_word_shifter (
  input  logic                    clk,
  input  logic                    rst,
  input  spi_word_pkg::spi_pins_t pins,
  input  spi_word_pkg::word_t     word_send_data,
  output logic                    cipo,
  output logic                    word_received,
  output spi_word_pkg::word_t     word_data_received
);

  spi_word_pkg::shift_state_t state;
  spi_word_pkg::word_t        rx_reg;   // incoming bits with the newest in the LSB
  spi_word_pkg::word_t        tx_reg;   // outgoing bits with the MSB on the wire
  spi_word_pkg::bit_cnt_t     bit_cnt;  // rising edges seen in this word
  logic                       last_bit;

  assign last_bit = (bit_cnt == `SPI_CNT_W'(`SPI_WORD_W - 1));

  // tx msb drives the pin directly
  // tx_reg is zero whenever idle so the pin sits low
  assign cipo = tx_reg[`SPI_WORD_W-1];

  // ########################################
  // receive shift register
  // ########################################
  always_ff @(posedge clk) begin
    if (state == spi_word_pkg::st_shift && pins.cs_active && pins.sck_rise) begin
      rx_reg <= {rx_reg[`SPI_WORD_W-2:0], pins.copi};   // sample on rise
    end
  end

  // ########################################
  // FSM, counter, transmit path
  // ########################################
  always_ff @(posedge clk) begin
    if (rst) begin
      state              <= spi_word_pkg::st_idle;
      bit_cnt            <= '0;
      tx_reg             <= '0;
      word_received      <= 1'b0;
      word_data_received <= '0;
    end else begin
      word_received <= 1'b0;   // strobe lasts one cycle only

      case (state)
        spi_word_pkg::st_idle: begin
          if (pins.cs_start) begin
            state   <= spi_word_pkg::st_shift;
            tx_reg  <= word_send_data;   // msb out before first rise
            bit_cnt <= '0;
          end
        end

        spi_word_pkg::st_shift: begin
          if (!pins.cs_active) begin
            // deselected so any partial word is dropped
            state   <= spi_word_pkg::st_idle;
            tx_reg  <= '0;
            bit_cnt <= '0;
          end else if (pins.sck_rise) begin
            if (last_bit) begin
              bit_cnt            <= '0;
              word_received      <= 1'b1;
              word_data_received <= {rx_reg[`SPI_WORD_W-2:0], pins.copi};
              tx_reg             <= word_send_data;   // reload for back to back words
            end else begin
              bit_cnt <= bit_cnt + `SPI_CNT_W'(1);
            end
          end else if (pins.sck_fall && bit_cnt != '0) begin
            // no shift on the fall right after a word boundary
            // so the freshly loaded msb stays on the pin
            tx_reg <= {tx_reg[`SPI_WORD_W-2:0], 1'b0};
          end
        end

        default: begin
          state <= spi_word_pkg::st_idle;
        end
      endcase
    end
  end

  // ########################################
  // assertions
  // ########################################

  // strobe never stretches even with fast back-to-back words
  a_strobe_single: assert property (
    @(posedge clk) disable iff (rst)
    word_received |=> !word_received
  );

  // counter wraps at the word boundary
  a_cnt_range: assert property (
    @(posedge clk) disable iff (rst)
    bit_cnt < `SPI_CNT_W'(`SPI_WORD_W)
  );

  // pin quiet while not selected
  a_cipo_idle: assert property (
    @(posedge clk) disable iff (rst)
    (state == spi_word_pkg::st_idle) |-> !cipo
  );

endmodule

// File: verilog/spi_word_top.sv
// top level of the SPI word target port
// pins in from the controller, word strobe and data out to local logic
`timescale 1ns/10ps

module spi_word_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                sck,
  input  logic                cs,               // active low
  input  logic                copi,
  input  spi_word_pkg::word_t word_send_data,   // sampled at cs fall and word end
  output logic                cipo,
  output logic                word_received,    // one clk pulse per word
  output spi_word_pkg::word_t word_data_received
);

  // synchronized levels and edge events
  spi_word_pkg::spi_pins_t pins;

  // ########################################
  // pin synchronizer
  // ########################################
  spi_pin_sync sync_i (
    .clk  (clk),
    .rst  (rst),
    .sck  (sck),
    .cs   (cs),
    .copi (copi),
    .pins (pins)
  );

  // ########################################
  // word shifter
  // ########################################
  spi_word_shifter shifter_i (
    .clk                (clk),
    .rst                (rst),
    .pins               (pins),
    .word_send_data     (word_send_data),
    .cipo               (cipo),
    .word_received      (word_received),
    .word_data_received (word_data_received)
  );

endmodule

// File: verif/spi_word_tb.sv
// testbench for the SPI word target port
// a mode 0 controller model replays frames from the testdata file
// and checks the received words and the cipo stream
`timescale 1ns/10ps
`include "spi_word_macros.svh"

module spi_word_tb;

  localparam int HALF       = 5;   // clk per sck level
  localparam int MAX_LINES  = 32;
  localparam int STROBE_MAX = 8;   // clk allowed from last rise to strobe

  logic                clk;
  logic                rst;
  logic                sck;
  logic                cs;     // active low
  logic                copi;
  spi_word_pkg::word_t word_send_data;
  logic                cipo;
  logic                word_received;
  spi_word_pkg::word_t word_data_received;

  spi_word_pkg::word_t vec_mem [0:4*MAX_LINES-1];   // 4 columns per frame
  spi_word_pkg::word_t last_full;     // copi word of the last complete frame
  spi_word_pkg::word_t strobe_data;   // word_data_received at the strobe
  int errors      = 0;
  int strobes     = 0;    // word_received pulses seen
  int cycles      = 0;
  int cycle_limit = 0;

  spi_word_top dut_i (
    .clk                (clk),
    .rst                (rst),
    .sck                (sck),
    .cs                 (cs),
    .copi               (copi),
    .word_send_data     (word_send_data),
    .cipo               (cipo),
    .word_received      (word_received),
    .word_data_received (word_data_received)
  );

  always #5 clk = ~clk;   // 10 ns

  // ########################################
  // monitors
  // ########################################
  always @(negedge clk) begin
    if (!rst && word_received) begin
      strobes     = strobes + 1;
      strobe_data = word_data_received;   // stable mid cycle
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: run went past %0d clk cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ########################################
  // compare tasks
  // ########################################
  task automatic check_word(input string name, input spi_word_pkg::word_t exp,
                            input spi_word_pkg::word_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // ########################################
  // controller model, one frame per line
  // ########################################
  task automatic run_frame(input int n);
    spi_word_pkg::word_t copi_word;
    spi_word_pkg::word_t send;
    spi_word_pkg::word_t seen;   // cipo bits sampled before each rise
    int   nbits;
    logic hold;
    int   strobes_before;
    int   waited;
    copi_word      = vec_mem[4*n];
    send           = vec_mem[4*n+1];
    nbits          = int'(vec_mem[4*n+2]);
    hold           = vec_mem[4*n+3][0];
    seen           = '0;
    strobes_before = strobes;

    @(posedge clk);
    if (cs) begin   // fresh frame, else word_send_data was set last word
      word_send_data <= send;
      cs             <= 1'b0;
    end
    copi <= copi_word[`SPI_WORD_W-1];

    for (int i = 0; i < nbits; i++) begin
      repeat (HALF - 1) @(posedge clk);   // rest of low phase
      @(negedge clk);
      seen[`SPI_WORD_W-1-i] = cipo;
      @(posedge clk);
      sck <= 1'b1;
      if (i == `SPI_WORD_W/2) begin
        // next word's data when chained, else junk that must not be used
        word_send_data <= hold ? vec_mem[4*n+5] : ~send;
      end
      waited = 0;
      if (i == `SPI_WORD_W-1) begin
        while (strobes == strobes_before && waited < STROBE_MAX) begin
          @(posedge clk);
          waited++;
        end
        if (strobes == strobes_before) begin
          errors++;
          $display("no word_received pulse within %0d clk of bit 64, frame %0d",
                   STROBE_MAX, n);
        end else begin
          check_word("word_data_received", copi_word, strobe_data);
        end
      end
      while (waited < HALF) begin   // pad high phase
        @(posedge clk);
        waited++;
      end
      sck <= 1'b0;
      if (i < nbits - 1) begin
        copi <= copi_word[`SPI_WORD_W-2-i];   // change on fall
      end
    end

    // only the clocked bits count, msb first
    check_word("cipo_stream", send >> (`SPI_WORD_W - nbits), seen >> (`SPI_WORD_W - nbits));
    if (nbits == `SPI_WORD_W) begin
      last_full = copi_word;
    end

    if (!hold) begin
      repeat (HALF) @(posedge clk);
      cs <= 1'b1;
      repeat (2*HALF) @(posedge clk);
      @(negedge clk);
      check_bit("cipo", 1'b0, cipo);   // deselected
      check_word("word_data_received", last_full, word_data_received);
    end
    if (strobes != strobes_before + int'(nbits == `SPI_WORD_W)) begin
      errors++;
      $display("frame %0d gave %0d word_received pulses for %0d bits",
               n, strobes - strobes_before, nbits);
    end
  endtask

  // ########################################
  // main sequence
  // ########################################
  initial begin
    int nlines;
    int total_bits;
    clk            = 1'b0;
    rst            = 1'b1;
    sck            = 1'b0;
    cs             = 1'b1;
    copi           = 1'b0;
    word_send_data = '0;
    last_full      = '0;
    strobe_data    = '0;
    for (int k = 0; k < 4*MAX_LINES; k++) begin
      vec_mem[k] = '0;
    end
    $readmemh("verif/spi_word_testdata.txt", vec_mem);

    nlines     = 0;
    total_bits = 0;
    while (nlines < MAX_LINES && vec_mem[4*nlines+2] != '0) begin   // count 0 ends list
      total_bits += int'(vec_mem[4*nlines+2]);
      nlines++;
    end
    if (nlines == 0) begin
      errors++;
      $display("no frames found in the testdata file");
    end
    cycle_limit = total_bits * 2 * HALF + nlines * 40 + 200;   // bits plus cs gaps

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_bit("word_received", 1'b0, word_received);
    check_bit("cipo", 1'b0, cipo);
    check_word("word_data_received", '0, word_data_received);

    for (int n = 0; n < nlines; n++) begin
      run_frame(n);
    end

    repeat (20) @(posedge clk);
    $display("done: %0d frames, %0d errors", nlines, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verif/spi_word_testdata.txt
// SPI frames, one per line, every field in hex
// columns: copi word, word_send_data, bits to clock (40 = full word), hold cs low into next line
// fewer than 40 bits is an abort ended by cs rising, always with hold 0
// a line with bit count 0 ends the list
00000000deadbeef 00000000005fffff 40 0
0123456789abcdef fedcba9876543210 40 0
a5a5a5a5a5a5a5a5 5a5a5a5a5a5a5a5a 40 1
ffffffffffffffff 0000000000000001 40 1
8000000000000001 00000000005fffff 40 0
3c3c3c3c3c3c3c3c c3c3c3c3c3c3c3c3 14 0
cafef00dcafef00d 1122334455667788 40 0
0000000000000000 ffffffffffffffff 40 1
123456789abcdef0 0f0e0d0c0b0a0908 21 0
fedcba9876543210 8000000000000000 40 0
5555555555555555 aaaaaaaaaaaaaaaa 01 0
0000000000000001 00000000deadbeef 40 0
0000000000000001 00000000deadbeef 40 1
7fffffffffffffff 00000000005fffff 40 1
00000000deadbeef 0123456789abcdef 40 0
0 0 0 0

// File: flist.f
+incdir+include
verilog/spi_word_pkg.sv
verilog/spi_pin_sync.sv
verilog/spi_word_shifter.sv
verilog/spi_word_top.sv
verif/spi_word_tb.sv

// File: Makefile
# Verilator build and run for the SPI word target port

SIM   := verilator
FLAGS := --binary --timing --assert
TOP   := spi_word_tb
FLIST := flist.f
OBJ   := obj_dir

.PHONY: sim clean

# build, run, and fail unless the pass line is printed
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ)
